// File: Makefile
# Verilator build and run of the dcache storage core testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := dcache_mem_tb
FILELIST := dcache_mem.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qx "All tests passed" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: dcache_mem.f
hdl/dcache_mem_pkg.sv
hdl/dcache_mem_if.sv
hdl/dcache_port_arbiter.sv
hdl/dcache_data_banks.sv
hdl/dcache_tag_array.sv
hdl/dcache_hit_select.sv
hdl/dcache_mem.sv
verification/dcache_mem_tb.sv

// File: hdl/dcache_data_banks.sv
// dcache data banks
// one memory per word offset, each entry holds the word of every way
module dcache_data_banks (
  input  logic        clk_i,
  bank_if.bank_mp     bank,
  output dcache_mem_pkg::word_t [dcache_mem_pkg::NUM_BANKS-1:0][dcache_mem_pkg::NUM_WAYS-1:0]
                      bank_rdata_o
);

  for (genvar k = 0; k < dcache_mem_pkg::NUM_BANKS; k++) begin : gen_bank

    dcache_mem_pkg::word_t [dcache_mem_pkg::NUM_WAYS-1:0] mem_q [dcache_mem_pkg::NUM_SETS];
    dcache_mem_pkg::word_t [dcache_mem_pkg::NUM_WAYS-1:0] rdata_q;
    logic wr_en;

    // fills and word writes both go through the byte enables
    assign wr_en = (bank.op[k] == dcache_mem_pkg::BANK_FILL) ||
                   (bank.op[k] == dcache_mem_pkg::BANK_WRITE_WORD);

    always_ff @(posedge clk_i) begin : p_write
      if (wr_en) begin
        for (int j = 0; j < dcache_mem_pkg::NUM_WAYS; j++) begin
          for (int b = 0; b < dcache_mem_pkg::BE_W; b++) begin
            if (bank.be[k][j][b]) begin
              mem_q[bank.idx[k]][j][8*b +: 8] <= bank.wdata[k][j][8*b +: 8];
            end
          end
        end
      end
    end

    // read data holds until the next read of this bank
    always_ff @(posedge clk_i) begin : p_read
      if (bank.op[k] == dcache_mem_pkg::BANK_READ) begin
        rdata_q <= mem_q[bank.idx[k]];
      end
    end

    assign bank_rdata_o[k] = rdata_q;

  end

endmodule

// File: hdl/dcache_hit_select.sv
// dcache hit way selection
// picks the looked-up word offset, then the word of the hitting way
module dcache_hit_select (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  dcache_mem_pkg::bank_sel_t rd_bank_sel_i,
  input  dcache_mem_pkg::word_t [dcache_mem_pkg::NUM_BANKS-1:0][dcache_mem_pkg::NUM_WAYS-1:0]
                                    bank_rdata_i,
  input  dcache_mem_pkg::way_mask_t hit_oh_i,
  output dcache_mem_pkg::word_t     rd_data_o
);

  dcache_mem_pkg::bank_sel_t bank_sel_q;
  dcache_mem_pkg::word_t [dcache_mem_pkg::NUM_WAYS-1:0] way_words;

  // bank select lines up with the bank read data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_sel_q <= '0;
    end else begin
      bank_sel_q <= rd_bank_sel_i;
    end
  end

  assign way_words = bank_rdata_i[bank_sel_q];

  // and-or mux over a hit that is one-hot or zero
  always_comb begin : p_way_mux
    rd_data_o = '0;
    for (int j = 0; j < dcache_mem_pkg::NUM_WAYS; j++) begin
      if (hit_oh_i[j]) begin
        rd_data_o = rd_data_o | way_words[j];
      end
    end
  end

endmodule

// File: hdl/dcache_mem.sv
// write-through L1 dcache storage core
// data banks, tag arrays, read port arbiter and hit selection
module dcache_mem (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  // read ports
  input  dcache_mem_pkg::tag_t      [dcache_mem_pkg::NUM_PORTS-1:0] rd_tag_i,
  input  dcache_mem_pkg::set_idx_t  [dcache_mem_pkg::NUM_PORTS-1:0] rd_idx_i,
  input  dcache_mem_pkg::line_off_t [dcache_mem_pkg::NUM_PORTS-1:0] rd_off_i,
  input  dcache_mem_pkg::port_mask_t                               rd_req_i,
  input  dcache_mem_pkg::port_mask_t                               rd_tag_only_i,
  input  dcache_mem_pkg::port_mask_t                               rd_prio_i,
  output dcache_mem_pkg::port_mask_t                               rd_ack_o,
  output dcache_mem_pkg::way_mask_t                                rd_vld_bits_o,
  output dcache_mem_pkg::way_mask_t                                rd_hit_oh_o,
  output dcache_mem_pkg::word_t                                    rd_data_o,
  // line fill
  input  logic                                                     wr_cl_vld_i,
  input  dcache_mem_pkg::way_mask_t                                wr_cl_we_i,
  input  dcache_mem_pkg::tag_t                                     wr_cl_tag_i,
  input  dcache_mem_pkg::set_idx_t                                 wr_cl_idx_i,
  input  dcache_mem_pkg::line_t                                    wr_cl_data_i,
  input  dcache_mem_pkg::line_be_t                                 wr_cl_be_i,
  input  dcache_mem_pkg::way_mask_t                                wr_vld_bits_i,
  // single word write
  input  dcache_mem_pkg::way_mask_t                                wr_req_i,
  output logic                                                     wr_ack_o,
  input  dcache_mem_pkg::set_idx_t                                 wr_idx_i,
  input  dcache_mem_pkg::line_off_t                                wr_off_i,
  input  dcache_mem_pkg::word_t                                    wr_data_i,
  input  logic [dcache_mem_pkg::BE_W-1:0]                          wr_be_i
);

  bank_if bank_bus ();
  tag_if  tag_bus ();

  dcache_mem_pkg::bank_sel_t rd_bank_sel;
  dcache_mem_pkg::word_t [dcache_mem_pkg::NUM_BANKS-1:0][dcache_mem_pkg::NUM_WAYS-1:0]
                             bank_rdata;

  dcache_port_arbiter i_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_prio_i     (rd_prio_i),
    .rd_tag_only_i (rd_tag_only_i),
    .rd_idx_i      (rd_idx_i),
    .rd_off_i      (rd_off_i),
    .rd_ack_o      (rd_ack_o),
    .wr_cl_vld_i   (wr_cl_vld_i),
    .wr_cl_we_i    (wr_cl_we_i),
    .wr_vld_bits_i (wr_vld_bits_i),
    .wr_cl_idx_i   (wr_cl_idx_i),
    .wr_cl_tag_i   (wr_cl_tag_i),
    .wr_cl_data_i  (wr_cl_data_i),
    .wr_cl_be_i    (wr_cl_be_i),
    .wr_req_i      (wr_req_i),
    .wr_ack_o      (wr_ack_o),
    .wr_idx_i      (wr_idx_i),
    .wr_off_i      (wr_off_i),
    .wr_data_i     (wr_data_i),
    .wr_be_i       (wr_be_i),
    .rd_bank_sel_o (rd_bank_sel),
    .bank          (bank_bus.arb_mp),
    .tag           (tag_bus.arb_mp)
  );

  dcache_data_banks i_data_banks (
    .clk_i        (clk_i),
    .bank         (bank_bus.bank_mp),
    .bank_rdata_o (bank_rdata)
  );

  dcache_tag_array i_tag_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .tag           (tag_bus.tag_mp),
    .rd_tag_i      (rd_tag_i),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_hit_oh_o   (rd_hit_oh_o)
  );

  dcache_hit_select i_hit_select (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_bank_sel_i (rd_bank_sel),
    .bank_rdata_i  (bank_rdata),
    .hit_oh_i      (rd_hit_oh_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

// File: hdl/dcache_mem_if.sv
// dcache storage access buses
// bank_if feeds the data banks, tag_if feeds the tag and valid arrays

interface bank_if;

  // per bank: opcode, set index, per-way byte enables and write words
  dcache_mem_pkg::bank_op_e [dcache_mem_pkg::NUM_BANKS-1:0] op;
  dcache_mem_pkg::set_idx_t [dcache_mem_pkg::NUM_BANKS-1:0] idx;
  logic [dcache_mem_pkg::NUM_BANKS-1:0][dcache_mem_pkg::NUM_WAYS-1:0]
        [dcache_mem_pkg::BE_W-1:0] be;
  dcache_mem_pkg::word_t [dcache_mem_pkg::NUM_BANKS-1:0][dcache_mem_pkg::NUM_WAYS-1:0] wdata;

  modport arb_mp (output op, idx, be, wdata);
  modport bank_mp (input op, idx, be, wdata);

endinterface

interface tag_if;

  dcache_mem_pkg::way_mask_t req;
  logic                      we;
  dcache_mem_pkg::set_idx_t  idx;
  dcache_mem_pkg::tag_t      wtag;
  dcache_mem_pkg::way_mask_t wvld;
  // granted read port and lookup flag, registered on the tag side
  dcache_mem_pkg::port_sel_t port;
  logic                      lookup;

  modport arb_mp (output req, we, idx, wtag, wvld, port, lookup);
  modport tag_mp (input req, we, idx, wtag, wvld, port, lookup);

endinterface

// File: hdl/dcache_mem_pkg.sv
// dcache storage core definitions
// cache geometry, storage types and the per-bank opcode
package dcache_mem_pkg;

  ////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////

  localparam int NUM_PORTS  = 3;
  localparam int NUM_WAYS   = 4;
  localparam int XLEN       = 32;
  localparam int LINE_WIDTH = 128;
  // one data bank per word offset in the line
  localparam int NUM_BANKS  = LINE_WIDTH / XLEN;
  localparam int BANK_SEL_W = $clog2(NUM_BANKS);
  localparam int WORD_ALIGN = $clog2(XLEN / 8);
  localparam int OFF_W      = $clog2(LINE_WIDTH / 8);
  localparam int IDX_W      = 6;
  localparam int NUM_SETS   = 2 ** IDX_W;
  localparam int TAG_W      = 20;
  localparam int BE_W       = XLEN / 8;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic [XLEN-1:0]              word_t;
  typedef logic [LINE_WIDTH-1:0]        line_t;
  typedef logic [LINE_WIDTH/8-1:0]      line_be_t;
  typedef logic [TAG_W-1:0]             tag_t;
  typedef logic [IDX_W-1:0]             set_idx_t;
  typedef logic [OFF_W-1:0]             line_off_t;
  typedef logic [BANK_SEL_W-1:0]        bank_sel_t;
  typedef logic [NUM_WAYS-1:0]          way_mask_t;
  typedef logic [NUM_PORTS-1:0]         port_mask_t;
  typedef logic [$clog2(NUM_PORTS)-1:0] port_sel_t;

  // what a data bank does in one cycle
  typedef enum logic [1:0] {
    BANK_IDLE       = 2'd0,
    BANK_READ       = 2'd1,
    BANK_WRITE_WORD = 2'd2,
    BANK_FILL       = 2'd3
  } bank_op_e;

endpackage

// File: hdl/dcache_port_arbiter.sv
// dcache read port arbiter
// round robin with priority masking, fill blocking and word-write collision check
module dcache_port_arbiter (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  dcache_mem_pkg::port_mask_t                              rd_req_i,
  input  dcache_mem_pkg::port_mask_t                              rd_prio_i,
  input  dcache_mem_pkg::port_mask_t                              rd_tag_only_i,
  input  dcache_mem_pkg::set_idx_t  [dcache_mem_pkg::NUM_PORTS-1:0] rd_idx_i,
  input  dcache_mem_pkg::line_off_t [dcache_mem_pkg::NUM_PORTS-1:0] rd_off_i,
  output dcache_mem_pkg::port_mask_t                              rd_ack_o,
  input  logic                                                    wr_cl_vld_i,
  input  dcache_mem_pkg::way_mask_t                               wr_cl_we_i,
  input  dcache_mem_pkg::way_mask_t                               wr_vld_bits_i,
  input  dcache_mem_pkg::set_idx_t                                wr_cl_idx_i,
  input  dcache_mem_pkg::tag_t                                    wr_cl_tag_i,
  input  dcache_mem_pkg::line_t                                   wr_cl_data_i,
  input  dcache_mem_pkg::line_be_t                                wr_cl_be_i,
  input  dcache_mem_pkg::way_mask_t                               wr_req_i,
  output logic                                                    wr_ack_o,
  input  dcache_mem_pkg::set_idx_t                                wr_idx_i,
  input  dcache_mem_pkg::line_off_t                               wr_off_i,
  input  dcache_mem_pkg::word_t                                   wr_data_i,
  input  logic [dcache_mem_pkg::BE_W-1:0]                         wr_be_i,
  output dcache_mem_pkg::bank_sel_t                               rd_bank_sel_o,
  bank_if.arb_mp                                                  bank,
  tag_if.arb_mp                                                   tag
);

  dcache_mem_pkg::port_mask_t req_prio, req_masked;
  dcache_mem_pkg::port_sel_t  rr_d, rr_q, gnt_idx;
  dcache_mem_pkg::bank_sel_t  wr_bank_sel;
  logic gnt_found, rd_grant, rd_data_req;

  ////////////////////////////////////////////////////////////
  // read arbitration
  ////////////////////////////////////////////////////////////

  // high priority requesters hide all low priority ones
  assign req_prio   = rd_req_i & rd_prio_i;
  assign req_masked = (|req_prio) ? req_prio : rd_req_i;

  // search upward from the pointer, wrapping at the last port
  always_comb begin : p_search
    int cand;
    gnt_found = 1'b0;
    gnt_idx   = rr_q;
    for (int k = 0; k < dcache_mem_pkg::NUM_PORTS; k++) begin
      cand = int'(rr_q) + k;
      if (cand >= dcache_mem_pkg::NUM_PORTS) begin
        cand = cand - dcache_mem_pkg::NUM_PORTS;
      end
      if (!gnt_found && req_masked[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = dcache_mem_pkg::port_sel_t'(cand);
      end
    end
  end

  // a fill owns every bank and the tags this cycle
  assign rd_grant    = gnt_found & ~wr_cl_vld_i;
  assign rd_data_req = rd_grant & ~rd_tag_only_i[gnt_idx];

  always_comb begin
    rd_ack_o = '0;
    if (rd_grant) begin
      rd_ack_o[gnt_idx] = 1'b1;
    end
  end

  assign rr_d = (gnt_idx == dcache_mem_pkg::port_sel_t'(dcache_mem_pkg::NUM_PORTS - 1)) ?
                '0 : gnt_idx + dcache_mem_pkg::port_sel_t'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (rd_grant) begin
      rr_q <= rr_d;
    end
  end

  assign rd_bank_sel_o = rd_off_i[gnt_idx][dcache_mem_pkg::OFF_W-1:dcache_mem_pkg::WORD_ALIGN];
  assign wr_bank_sel   = wr_off_i[dcache_mem_pkg::OFF_W-1:dcache_mem_pkg::WORD_ALIGN];

  // word write only yields to a data read of the same bank
  assign wr_ack_o = (|wr_req_i) & ~wr_cl_vld_i &
                    (~rd_data_req | (rd_bank_sel_o != wr_bank_sel));

  ////////////////////////////////////////////////////////////
  // bank and tag accesses
  ////////////////////////////////////////////////////////////

  always_comb begin : p_bank_ctrl
    for (int k = 0; k < dcache_mem_pkg::NUM_BANKS; k++) begin
      bank.op[k]  = dcache_mem_pkg::BANK_IDLE;
      bank.idx[k] = wr_idx_i;
      for (int j = 0; j < dcache_mem_pkg::NUM_WAYS; j++) begin
        bank.be[k][j]    = '0;
        bank.wdata[k][j] = wr_data_i;
        if (wr_cl_vld_i) begin
          bank.wdata[k][j] = wr_cl_data_i[k*dcache_mem_pkg::XLEN +: dcache_mem_pkg::XLEN];
          if (wr_cl_we_i[j]) begin
            bank.be[k][j] = wr_cl_be_i[k*dcache_mem_pkg::BE_W +: dcache_mem_pkg::BE_W];
          end
        end else if (wr_ack_o && wr_req_i[j] &&
                     wr_bank_sel == dcache_mem_pkg::bank_sel_t'(k)) begin
          bank.be[k][j] = wr_be_i;
        end
      end
      if (wr_cl_vld_i) begin
        bank.op[k]  = dcache_mem_pkg::BANK_FILL;
        bank.idx[k] = wr_cl_idx_i;
      end else if (rd_data_req && rd_bank_sel_o == dcache_mem_pkg::bank_sel_t'(k)) begin
        bank.op[k]  = dcache_mem_pkg::BANK_READ;
        bank.idx[k] = rd_idx_i[gnt_idx];
      end else if (wr_ack_o && wr_bank_sel == dcache_mem_pkg::bank_sel_t'(k)) begin
        bank.op[k] = dcache_mem_pkg::BANK_WRITE_WORD;
      end
    end
  end

  assign tag.req    = wr_cl_vld_i ? wr_cl_we_i : (rd_grant ? '1 : '0);
  assign tag.we     = wr_cl_vld_i;
  assign tag.idx    = wr_cl_vld_i ? wr_cl_idx_i : rd_idx_i[gnt_idx];
  assign tag.wtag   = wr_cl_tag_i;
  assign tag.wvld   = wr_vld_bits_i;
  assign tag.port   = gnt_idx;
  assign tag.lookup = rd_grant;

endmodule

// File: hdl/dcache_tag_array.sv
// dcache tag and valid arrays
// stores tags and valid bits per way and compares against the late tag
module dcache_tag_array (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  tag_if.tag_mp                                               tag,
  input  dcache_mem_pkg::tag_t [dcache_mem_pkg::NUM_PORTS-1:0] rd_tag_i,
  output dcache_mem_pkg::way_mask_t                           rd_vld_bits_o,
  output dcache_mem_pkg::way_mask_t                           rd_hit_oh_o
);

  dcache_mem_pkg::way_mask_t vld_q [dcache_mem_pkg::NUM_SETS];
  dcache_mem_pkg::way_mask_t vld_rd_q;
  dcache_mem_pkg::tag_t      tag_rd_q [dcache_mem_pkg::NUM_WAYS];
  dcache_mem_pkg::port_sel_t port_q;
  logic                      lookup_q;
  dcache_mem_pkg::tag_t      late_tag;

  ////////////////////////////////////////////////////////////
  // tag memories
  ////////////////////////////////////////////////////////////

  for (genvar j = 0; j < dcache_mem_pkg::NUM_WAYS; j++) begin : gen_way
    dcache_mem_pkg::tag_t mem_q [dcache_mem_pkg::NUM_SETS];

    always_ff @(posedge clk_i) begin : p_tag_mem
      if (tag.req[j]) begin
        if (tag.we) begin
          mem_q[tag.idx] <= tag.wtag;
        end else begin
          tag_rd_q[j] <= mem_q[tag.idx];
        end
      end
    end
  end

  // valid bits live in flops so reset can clear them
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      vld_q    <= '{default: '0};
      vld_rd_q <= '0;
      port_q   <= '0;
      lookup_q <= 1'b0;
    end else begin
      lookup_q <= tag.lookup;
      if (tag.lookup) begin
        vld_rd_q <= vld_q[tag.idx];
        port_q   <= tag.port;
      end
      if (tag.we) begin
        for (int j = 0; j < dcache_mem_pkg::NUM_WAYS; j++) begin
          if (tag.req[j]) begin
            vld_q[tag.idx][j] <= tag.wvld[j];
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // hit generation
  ////////////////////////////////////////////////////////////

  // the port's tag arrives one cycle after its grant
  assign late_tag      = rd_tag_i[port_q];
  assign rd_vld_bits_o = vld_rd_q;

  for (genvar j = 0; j < dcache_mem_pkg::NUM_WAYS; j++) begin : gen_hit
    assign rd_hit_oh_o[j] = lookup_q & vld_rd_q[j] & (tag_rd_q[j] == late_tag);
  end

endmodule

// File: verification/dcache_mem_tb.sv
// dcache storage core testbench
// a reference model of tags, valid bits and lines checks the DUT every cycle
module dcache_mem_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                                                      clk_i = 1'b0;
  logic                                                      rst_ni;
  dcache_mem_pkg::tag_t      [dcache_mem_pkg::NUM_PORTS-1:0] rd_tag_i;
  dcache_mem_pkg::set_idx_t  [dcache_mem_pkg::NUM_PORTS-1:0] rd_idx_i;
  dcache_mem_pkg::line_off_t [dcache_mem_pkg::NUM_PORTS-1:0] rd_off_i;
  dcache_mem_pkg::port_mask_t      rd_req_i, rd_tag_only_i, rd_prio_i, rd_ack_o;
  dcache_mem_pkg::way_mask_t       rd_vld_bits_o, rd_hit_oh_o, wr_cl_we_i, wr_vld_bits_i;
  dcache_mem_pkg::way_mask_t       wr_req_i;
  dcache_mem_pkg::word_t           rd_data_o, wr_data_i;
  dcache_mem_pkg::tag_t            wr_cl_tag_i;
  dcache_mem_pkg::set_idx_t        wr_cl_idx_i, wr_idx_i;
  dcache_mem_pkg::line_t           wr_cl_data_i;
  dcache_mem_pkg::line_be_t        wr_cl_be_i;
  dcache_mem_pkg::line_off_t       wr_off_i;
  logic [dcache_mem_pkg::BE_W-1:0] wr_be_i;
  logic                            wr_cl_vld_i, wr_ack_o;

  // reference model of the storage
  dcache_mem_pkg::tag_t      tag_m  [dcache_mem_pkg::NUM_WAYS][dcache_mem_pkg::NUM_SETS];
  dcache_mem_pkg::line_t     line_m [dcache_mem_pkg::NUM_WAYS][dcache_mem_pkg::NUM_SETS];
  dcache_mem_pkg::way_mask_t vld_m  [dcache_mem_pkg::NUM_SETS];
  int rr_m;
  // lookup granted in the previous cycle
  logic pend, pend_tonly;
  int   pend_port;
  dcache_mem_pkg::way_mask_t pend_vld;
  dcache_mem_pkg::tag_t      pend_tags  [dcache_mem_pkg::NUM_WAYS];
  dcache_mem_pkg::word_t     pend_words [dcache_mem_pkg::NUM_WAYS];

  int errors, checks, seed;
  dcache_mem_pkg::tag_t t1, t2, t3;

  dcache_mem uut (.*);

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // expected behavior
  ////////////////////////////////////////////////////////////

  function automatic int bank_of(dcache_mem_pkg::line_off_t off);
    return int'(off) >> dcache_mem_pkg::WORD_ALIGN;
  endfunction

  // high priority candidates first and round robin from the pointer
  function automatic int exp_grant();
    dcache_mem_pkg::port_mask_t cand;
    int p;
    cand = (|(rd_req_i & rd_prio_i)) ? (rd_req_i & rd_prio_i) : rd_req_i;
    if (wr_cl_vld_i) begin
      return -1;
    end
    for (int k = 0; k < dcache_mem_pkg::NUM_PORTS; k++) begin
      p = (rr_m + k) % dcache_mem_pkg::NUM_PORTS;
      if (cand[p]) begin
        return p;
      end
    end
    return -1;
  endfunction

  function automatic logic exp_wr_ack(int g);
    if (wr_req_i == '0 || wr_cl_vld_i) begin
      return 1'b0;
    end
    return g < 0 || rd_tag_only_i[g] || bank_of(rd_off_i[g]) != bank_of(wr_off_i);
  endfunction

  task automatic check(string name, logic [127:0] got, logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // one clock cycle with the checks before the rising edge and the model update after it
  task automatic step();
    int g;
    int idx;
    logic wa;
    dcache_mem_pkg::way_mask_t hit;
    dcache_mem_pkg::word_t     word;
    #1;
    g  = exp_grant();
    wa = exp_wr_ack(g);
    check("rd_ack_o", 128'(rd_ack_o), (g >= 0) ? (128'd1 << g) : 128'd0);
    check("wr_ack_o", 128'(wr_ack_o), 128'(wa));
    hit  = '0;
    word = '0;
    if (pend) begin
      for (int w = 0; w < dcache_mem_pkg::NUM_WAYS; w++) begin
        hit[w] = pend_vld[w] && pend_tags[w] == rd_tag_i[pend_port];
        if (hit[w]) begin
          word = pend_words[w];
        end
      end
      check("rd_vld_bits_o", 128'(rd_vld_bits_o), 128'(pend_vld));
      if (!pend_tonly && hit != '0) begin
        check("rd_data_o", 128'(rd_data_o), 128'(word));
      end
    end
    check("rd_hit_oh_o", 128'(rd_hit_oh_o), 128'(hit));
    @(posedge clk_i);
    pend = (g >= 0);
    if (pend) begin
      idx        = int'(rd_idx_i[g]);
      pend_port  = g;
      pend_tonly = rd_tag_only_i[g];
      pend_vld   = vld_m[idx];
      for (int w = 0; w < dcache_mem_pkg::NUM_WAYS; w++) begin
        pend_tags[w]  = tag_m[w][idx];
        pend_words[w] = line_m[w][idx][dcache_mem_pkg::XLEN*bank_of(rd_off_i[g]) +:
                                       dcache_mem_pkg::XLEN];
      end
      rr_m = (g + 1) % dcache_mem_pkg::NUM_PORTS;
    end
    for (int w = 0; w < dcache_mem_pkg::NUM_WAYS; w++) begin
      if (wr_cl_vld_i && wr_cl_we_i[w]) begin
        tag_m[w][wr_cl_idx_i]    = wr_cl_tag_i;
        vld_m[wr_cl_idx_i][w]    = wr_vld_bits_i[w];
        for (int b = 0; b < dcache_mem_pkg::LINE_WIDTH / 8; b++) begin
          if (wr_cl_be_i[b]) begin
            line_m[w][wr_cl_idx_i][8*b +: 8] = wr_cl_data_i[8*b +: 8];
          end
        end
      end
      if (wa && wr_req_i[w]) begin
        for (int b = 0; b < dcache_mem_pkg::BE_W; b++) begin
          if (wr_be_i[b]) begin
            line_m[w][wr_idx_i][dcache_mem_pkg::XLEN*bank_of(wr_off_i) + 8*b +: 8] =
              wr_data_i[8*b +: 8];
          end
        end
      end
    end
    @(negedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic idle();
    rd_req_i      = '0;
    rd_prio_i     = '0;
    rd_tag_only_i = '0;
    wr_cl_vld_i   = 1'b0;
    wr_req_i      = '0;
  endtask

  task automatic fill(dcache_mem_pkg::set_idx_t idx, dcache_mem_pkg::way_mask_t we,
                      dcache_mem_pkg::way_mask_t vld, dcache_mem_pkg::tag_t t);
    wr_cl_vld_i   = 1'b1;
    wr_cl_idx_i   = idx;
    wr_cl_we_i    = we;
    wr_vld_bits_i = vld;
    wr_cl_tag_i   = t;
    wr_cl_data_i  = {$random(seed), $random(seed), $random(seed), $random(seed)};
    step();
    idle();
  endtask

  // grant cycle followed by the result cycle with the late tag on the port
  task automatic lookup(int p, dcache_mem_pkg::set_idx_t idx, dcache_mem_pkg::line_off_t off,
                        dcache_mem_pkg::tag_t t, logic tonly);
    idle();
    rd_req_i[p]      = 1'b1;
    rd_idx_i[p]      = idx;
    rd_off_i[p]      = off;
    rd_tag_i[p]      = t;
    rd_tag_only_i[p] = tonly;
    step();
    idle();
    step();
  endtask

  task automatic report(string name, int errs_before);
    $display("test %-16s %s", name, (errors == errs_before) ? "ok" : "mismatches");
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    int e0;
    seed   = 32'hc4f;
    errors = 0;
    checks = 0;
    rr_m   = 0;
    pend   = 1'b0;
    vld_m  = '{default: '0};
    rst_ni = 1'b0;
    idle();
    rd_tag_i      = '0;
    rd_idx_i      = '0;
    rd_off_i      = '0;
    wr_cl_we_i    = '0;
    wr_vld_bits_i = '0;
    wr_cl_tag_i   = '0;
    wr_cl_idx_i   = '0;
    wr_cl_data_i  = '0;
    wr_cl_be_i    = '1;
    wr_idx_i      = '0;
    wr_off_i      = '0;
    wr_data_i     = '0;
    wr_be_i       = '0;
    t1 = dcache_mem_pkg::tag_t'($random(seed));
    t2 = dcache_mem_pkg::tag_t'($random(seed));
    t3 = dcache_mem_pkg::tag_t'($random(seed));
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    e0 = errors;
    fill(6'd5, 4'b0100, 4'b0100, t1);
    lookup(0, 6'd5, 4'h8, t1, 1'b0);
    lookup(1, 6'd5, 4'hc, t1, 1'b0);
    report("fill_hit", e0);

    e0 = errors;
    lookup(1, 6'd5, 4'h0, t1 ^ 20'h1, 1'b0);
    // a fill with the valid bit low invalidates the way
    fill(6'd5, 4'b0100, 4'b0000, t1);
    lookup(2, 6'd5, 4'h0, t1, 1'b0);
    report("miss_invalidate", e0);

    e0 = errors;
    fill(6'd9, 4'b0001, 4'b0001, t2);
    wr_req_i  = 4'b0001;
    wr_idx_i  = 6'd9;
    wr_off_i  = 4'h4;
    wr_data_i = $random(seed);
    wr_be_i   = 4'b0101;
    step();
    idle();
    lookup(0, 6'd9, 4'h4, t2, 1'b0);
    report("word_write", e0);

    e0 = errors;
    fill(6'd12, 4'b1000, 4'b1000, t3);
    rd_req_i[0] = 1'b1;
    rd_idx_i[0] = 6'd12;
    rd_off_i[0] = 4'h8;
    rd_tag_i[0] = t3;
    wr_req_i    = 4'b1000;
    wr_idx_i    = 6'd12;
    wr_off_i    = 4'h8;
    wr_data_i   = $random(seed);
    wr_be_i     = 4'b1111;
    // same bank so the write waits
    step();
    rd_off_i[0] = 4'h0;
    step();
    rd_off_i[0]      = 4'h8;
    rd_tag_only_i[0] = 1'b1;
    // tag-only read leaves the data bank free
    step();
    idle();
    step();
    report("collision", e0);

    e0 = errors;
    for (int p = 0; p < dcache_mem_pkg::NUM_PORTS; p++) begin
      rd_idx_i[p] = 6'd9;
      rd_off_i[p] = dcache_mem_pkg::line_off_t'(4 * p);
      rd_tag_i[p] = t2;
    end
    rd_req_i = 3'b111;
    repeat (4) step();
    rd_prio_i = 3'b010;
    repeat (2) step();
    wr_req_i = 4'b0001;
    wr_off_i = 4'h0;
    fill(6'd40, 4'b0010, 4'b0010, t1);
    step();
    report("arbitration", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // reset plus the cycles of each test, with the sum doubled as margin
  initial begin : watchdog
    int limit;
    limit = 2 * (4 + 5 + 5 + 4 + 5 + 8);
    repeat (limit) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d cycles", limit);
    $display("Some tests failed");
    $finish;
  end

endmodule
